// ==== rtl/mbw_pkg.sv ====
// Macroblock write-back constants
// Burst shape and address step shared by the AXI write path

`default_nettype none

package mbw_pkg;

    // --------------------
    // Burst shape
    // --------------------
    // One fixed-length burst per macroblock
    localparam int MB_BEATS = 7;

    // Holds an 11-bit by 11-bit product
    localparam int MB_CNT_W = 22;

    localparam int BEAT_CNT_W = 3;

    localparam logic [7:0] AWLEN_VAL = 8'(MB_BEATS - 1);

    // --------------------
    // Helpers
    // --------------------
    // AXI size code from bus width in bytes
    function automatic logic [2:0] AWSIZE_FN(input int unsigned bytes);
        return 3'($clog2(bytes));
    endfunction

    // Byte-address step from one macroblock to the next
    function automatic int unsigned MB_STEP_FN(input int unsigned bytes);
        return MB_BEATS * bytes;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/mb_job_if.sv ====
// Job interface between write control and the W data channel
// Control side announces the job, data side reports burst progress

`timescale 1ns/1ps
`default_nettype none

interface mb_job_if #(
    parameter int MB_CNT_W = 22
);

    // Macroblock total valid from the cycle after start
    logic [MB_CNT_W-1:0] mb_total;
    // One-cycle pulse aligned with a valid mb_total
    logic                job_start;
    // One-cycle pulse per accepted wlast beat
    logic                burst_done;
    // Level that is high once no beats are left to send for this job
    logic                data_idle;

    modport ctrl (
        output mb_total,
        output job_start,
        input  burst_done,
        input  data_idle
    );

    modport data (
        input  mb_total,
        input  job_start,
        output burst_done,
        output data_idle
    );

endinterface

`default_nettype wire

// ==== rtl/mb_fifo.sv ====
// Encoder output FIFO
// Register-array FIFO in show-ahead mode, so the head word is
// visible on dout whenever empty is low

`timescale 1ns/1ps
`default_nettype none

module mb_fifo #(
    parameter int DATA_W     = 128,
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr,
    input  logic [DATA_W-1:0] din,
    input  logic              rd,
    output logic [DATA_W-1:0] dout,
    output logic              empty,
    output logic              full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    // Writes while full are dropped
    assign push  = wr && !full;
    assign pop   = rd && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mb_wr_ctrl.sv ====
// Write-back job control
// Issues one AW burst per macroblock, counts B responses with a cap on
// outstanding bursts, and pulses done once every response is back

`timescale 1ns/1ps
`default_nettype none

module mb_wr_ctrl
    import mbw_pkg::*;
#(
    parameter int DATA_W          = 128,
    parameter int ADDR_W          = 32,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_pulse,
    input  logic [31:0]       mb_w,
    input  logic [31:0]       mb_h,
    input  logic [ADDR_W-1:0] base_addr,
    mb_job_if.ctrl            job,
    output logic [ADDR_W-1:0] m_axi_awaddr,
    output logic [7:0]        m_axi_awlen,
    output logic [2:0]        m_axi_awsize,
    output logic [1:0]        m_axi_awburst,
    output logic              m_axi_awvalid,
    input  logic              m_axi_awready,
    input  logic [1:0]        bresp,
    input  logic              bvalid,
    output logic              bready,
    output logic              done_pulse,
    output logic              busy,
    output logic              resp_err
);

    localparam int                OUT_W   = $clog2(MAX_OUTSTANDING + 1);
    localparam logic [ADDR_W-1:0] MB_STEP = ADDR_W'(MB_STEP_FN(DATA_W / 8));

    logic [MB_CNT_W-1:0] mb_total;
    logic [MB_CNT_W-1:0] aw_cnt;
    logic [MB_CNT_W-1:0] aw_cnt_nxt;
    logic [MB_CNT_W-1:0] w_cnt;
    logic [MB_CNT_W-1:0] b_cnt;
    logic [MB_CNT_W-1:0] b_cnt_nxt;
    logic [OUT_W-1:0]    out_cnt;
    logic [OUT_W-1:0]    out_cnt_nxt;
    logic                job_start_q;
    logic                aw_fire;
    logic                resp_fire;
    logic                finish;

    // Fixed INCR burst shape
    assign m_axi_awlen   = AWLEN_VAL;
    assign m_axi_awsize  = AWSIZE_FN(DATA_W / 8);
    assign m_axi_awburst = 2'b01;
    assign bready        = 1'b1;

    assign job.mb_total  = mb_total;
    assign job.job_start = job_start_q;

    // --------------------
    // Next-count logic
    // --------------------
    always_comb begin
        aw_fire     = m_axi_awvalid && m_axi_awready;
        // A response only counts once its burst's data has gone out
        resp_fire   = bvalid && bready && busy && (b_cnt < w_cnt);
        aw_cnt_nxt  = aw_cnt + MB_CNT_W'(aw_fire);
        b_cnt_nxt   = b_cnt + MB_CNT_W'(resp_fire);
        out_cnt_nxt = out_cnt + OUT_W'(aw_fire) - OUT_W'(resp_fire);
        // Zero-size jobs finish as soon as the total is known
        finish      = busy && job.data_idle && (b_cnt_nxt == mb_total);
    end

    // --------------------
    // Job and channel state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb_total      <= '0;
            aw_cnt        <= '0;
            w_cnt         <= '0;
            b_cnt         <= '0;
            out_cnt       <= '0;
            job_start_q   <= 1'b0;
            m_axi_awvalid <= 1'b0;
            done_pulse    <= 1'b0;
            busy          <= 1'b0;
            resp_err      <= 1'b0;
        end else begin
            job_start_q <= start_pulse;
            if (start_pulse) begin
                // Only the low 11 bits of each dimension are used
                mb_total      <= MB_CNT_W'(mb_w[10:0]) * MB_CNT_W'(mb_h[10:0]);
                aw_cnt        <= '0;
                w_cnt         <= '0;
                b_cnt         <= '0;
                out_cnt       <= '0;
                m_axi_awvalid <= 1'b0;
                done_pulse    <= 1'b0;
                busy          <= 1'b1;
                resp_err      <= 1'b0;
            end else begin
                aw_cnt  <= aw_cnt_nxt;
                b_cnt   <= b_cnt_nxt;
                out_cnt <= out_cnt_nxt;
                if (job.burst_done) begin
                    w_cnt <= w_cnt + 1'b1;
                end
                // New request only once the previous one is taken
                if (!m_axi_awvalid || aw_fire) begin
                    m_axi_awvalid <= busy && !finish && (aw_cnt_nxt < mb_total)
                                     && (out_cnt_nxt < OUT_W'(MAX_OUTSTANDING));
                end
                if (resp_fire && (bresp != 2'b00)) begin
                    resp_err <= 1'b1;
                end
                done_pulse <= finish;
                if (finish) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Running burst address
    always_ff @(posedge clk) begin
        if (start_pulse) begin
            m_axi_awaddr <= base_addr;
        end else if (aw_fire) begin
            m_axi_awaddr <= m_axi_awaddr + MB_STEP;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/wdata_channel.sv ====
// AXI write data channel
// Streams MB_BEATS FIFO words per macroblock with wlast on the final
// beat; wvalid follows FIFO occupancy only, never wready

`timescale 1ns/1ps
`default_nettype none

module wdata_channel
    import mbw_pkg::*;
#(
    parameter int DATA_W = 128
) (
    input  logic                clk,
    input  logic                rst_n,
    mb_job_if.data              job,
    input  logic                fifo_empty,
    input  logic [DATA_W-1:0]   fifo_dout,
    output logic                fifo_rd,
    output logic [DATA_W-1:0]   m_axi_wdata,
    output logic [DATA_W/8-1:0] m_axi_wstrb,
    output logic                m_axi_wvalid,
    output logic                m_axi_wlast,
    input  logic                m_axi_wready
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] SEND = 2'd1;
    localparam logic [1:0] DONE = 2'd2;

    logic [1:0]            state;
    logic [1:0]            state_nxt;
    logic [BEAT_CNT_W-1:0] beat_cnt;
    logic [MB_CNT_W-1:0]   burst_cnt;
    logic                  last_beat;
    logic                  all_sent;
    logic                  beat_fire;

    assign last_beat = (beat_cnt == BEAT_CNT_W'(MB_BEATS - 1));
    assign all_sent  = (burst_cnt == job.mb_total);

    // Show-ahead FIFO head goes straight onto the bus
    assign m_axi_wdata    = fifo_dout;
    assign m_axi_wstrb    = '1;
    assign m_axi_wvalid   = (state == SEND) && !fifo_empty;
    assign m_axi_wlast    = (state == SEND) && last_beat;
    assign beat_fire      = m_axi_wvalid && m_axi_wready;
    assign fifo_rd        = beat_fire;

    assign job.burst_done = beat_fire && last_beat;
    assign job.data_idle  = (state == IDLE) || ((state == DONE) && all_sent);

    // --------------------
    // Burst sequencing
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (job.job_start && (job.mb_total != '0)) begin
                    state_nxt = SEND;
                end
            end
            // An empty FIFO simply stalls here
            SEND: begin
                if (job.burst_done) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = all_sent ? IDLE : SEND;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            beat_cnt  <= '0;
            burst_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (job.job_start) begin
                beat_cnt  <= '0;
                burst_cnt <= '0;
            end else if (beat_fire) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                if (last_beat) begin
                    burst_cnt <= burst_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mb_writeback_top.sv ====
// Macroblock write-back top level
// Encoder FIFO, AW/B control and W data channel on plain AXI ports

`timescale 1ns/1ps
`default_nettype none

module mb_writeback_top
    import mbw_pkg::*;
#(
    parameter int DATA_W          = 128,
    parameter int ADDR_W          = 32,
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    // Job control and status
    input  logic                start_pulse,
    input  logic [31:0]         mb_w,
    input  logic [31:0]         mb_h,
    input  logic [ADDR_W-1:0]   base_addr,
    output logic                done_pulse,
    output logic                busy,
    output logic                resp_err,
    // Encoder side
    input  logic                enc_wr,
    input  logic [DATA_W-1:0]   enc_data,
    output logic                enc_full,
    // AXI write address
    output logic [ADDR_W-1:0]   m_axi_awaddr,
    output logic [7:0]          m_axi_awlen,
    output logic [2:0]          m_axi_awsize,
    output logic [1:0]          m_axi_awburst,
    output logic                m_axi_awvalid,
    input  logic                m_axi_awready,
    // AXI write data
    output logic [DATA_W-1:0]   m_axi_wdata,
    output logic [DATA_W/8-1:0] m_axi_wstrb,
    output logic                m_axi_wvalid,
    output logic                m_axi_wlast,
    input  logic                m_axi_wready,
    // AXI write response
    input  logic [1:0]          m_axi_bresp,
    input  logic                m_axi_bvalid,
    output logic                m_axi_bready
);

    logic              fifo_empty;
    logic [DATA_W-1:0] fifo_dout;
    logic              fifo_rd;

    mb_job_if #(.MB_CNT_W(MB_CNT_W)) job ();

    mb_fifo #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (enc_wr),
        .din   (enc_data),
        .rd    (fifo_rd),
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  (enc_full)
    );

    mb_wr_ctrl #(
        .DATA_W          (DATA_W),
        .ADDR_W          (ADDR_W),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_pulse   (start_pulse),
        .mb_w          (mb_w),
        .mb_h          (mb_h),
        .base_addr     (base_addr),
        .job           (job.ctrl),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awlen   (m_axi_awlen),
        .m_axi_awsize  (m_axi_awsize),
        .m_axi_awburst (m_axi_awburst),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .bresp         (m_axi_bresp),
        .bvalid        (m_axi_bvalid),
        .bready        (m_axi_bready),
        .done_pulse    (done_pulse),
        .busy          (busy),
        .resp_err      (resp_err)
    );

    wdata_channel #(
        .DATA_W (DATA_W)
    ) u_wdata (
        .clk          (clk),
        .rst_n        (rst_n),
        .job          (job.data),
        .fifo_empty   (fifo_empty),
        .fifo_dout    (fifo_dout),
        .fifo_rd      (fifo_rd),
        .m_axi_wdata  (m_axi_wdata),
        .m_axi_wstrb  (m_axi_wstrb),
        .m_axi_wvalid (m_axi_wvalid),
        .m_axi_wlast  (m_axi_wlast),
        .m_axi_wready (m_axi_wready)
    );

endmodule

`default_nettype wire

// ==== sim/tb_mb_writeback.sv ====
// Testbench for the macroblock write-back stage
// Trace-driven jobs, a randomly stalling AXI slave and in-order checks

`timescale 1ns/1ps
`default_nettype none

module tb_mb_writeback
    import mbw_pkg::*;
;

    localparam int DATA_W     = 128;
    localparam int ADDR_W     = 32;
    // Shallow FIFO and a low cap so both back-pressure paths engage
    localparam int FIFO_DEPTH = 4;
    localparam int MAX_OUT    = 2;
    localparam int TIMEOUT    = 5000;

    logic clk, rst_n, start_pulse, done_pulse, busy, resp_err;
    logic [31:0] mb_w, mb_h;
    logic [ADDR_W-1:0] base_addr, m_axi_awaddr;
    logic enc_wr, enc_full;
    logic [DATA_W-1:0] enc_data, m_axi_wdata;
    logic [7:0] m_axi_awlen;
    logic [2:0] m_axi_awsize;
    logic [1:0] m_axi_awburst, m_axi_bresp;
    logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wlast, m_axi_wready;
    logic [DATA_W/8-1:0] m_axi_wstrb;
    logic m_axi_bvalid, m_axi_bready;

    // Job bookkeeping shared by driver and monitor
    logic [DATA_W-1:0] exp_words[$];
    logic [31:0] job_w, job_h;
    logic [ADDR_W-1:0] job_base;
    int aw_cnt, w_idx, w_bursts, b_cnt, done_cnt, exp_bursts, feed_idx, err_idx;
    int fifo_occ;
    bit err_en, b_seen;
    logic [15:0] lfsr_q = 16'd16477;

    mb_writeback_top #(
        .DATA_W          (DATA_W),
        .ADDR_W          (ADDR_W),
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_OUTSTANDING (MAX_OUT)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 stepped once per bit
    function automatic logic rand_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // --------------------
    // Slave and encoder driver
    // --------------------
    initial begin
        forever begin
            @(posedge clk);
            #10;
            if (rst_n) begin
                m_axi_awready = rand_bit();
                m_axi_wready  = rand_bit();
                if (!(m_axi_bvalid && !b_seen)) begin
                    m_axi_bvalid = 1'b0;
                    // Answer only bursts whose address and data both arrived
                    if (b_cnt < aw_cnt && b_cnt < w_bursts && rand_bit()) begin
                        m_axi_bvalid = 1'b1;
                        m_axi_bresp  = (err_en && b_cnt == err_idx) ? 2'b10 : 2'b00;
                    end
                end
                b_seen = 1'b0;
                // Slow encoder pushing about every other cycle
                if (feed_idx < exp_words.size() && !enc_full && rand_bit()) begin
                    enc_wr   = 1'b1;
                    enc_data = exp_words[feed_idx];
                    feed_idx++;
                end else begin
                    enc_wr = 1'b0;
                end
            end
        end
    end

    // --------------------
    // Mid-cycle monitor
    // --------------------
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && m_axi_awvalid && m_axi_awready) begin
                if (aw_cnt >= exp_bursts)
                    abort_run("An AW burst was issued beyond the job's macroblock count");
                check_addr(m_axi_awaddr,
                           job_base + ADDR_W'(aw_cnt * MB_BEATS * (DATA_W / 8)), "awaddr");
                check_flag(m_axi_awlen == 8'(MB_BEATS - 1), 1'b1, "awlen match");
                check_flag(m_axi_awsize == 3'($clog2(DATA_W / 8)), 1'b1, "awsize match");
                check_flag(m_axi_awburst == 2'b01, 1'b1, "awburst INCR");
                aw_cnt++;
            end
            // Encoder-side full flag against the expected FIFO occupancy
            check_flag(enc_full, fifo_occ == FIFO_DEPTH, "enc_full");
            fifo_occ = fifo_occ + int'(enc_wr && !enc_full)
                       - int'(m_axi_wvalid && m_axi_wready);
            if (rst_n && m_axi_wvalid && m_axi_wready) begin
                if (w_idx >= exp_words.size())
                    abort_run("A W beat arrived beyond the job's payload");
                check_data(m_axi_wdata, exp_words[w_idx], "wdata");
                check_flag(m_axi_wlast, (w_idx % MB_BEATS) == MB_BEATS - 1, "wlast");
                check_flag(m_axi_wstrb == '1, 1'b1, "wstrb all ones");
                if (m_axi_wlast) w_bursts++;
                w_idx++;
            end
            if (rst_n && m_axi_bvalid) begin
                check_flag(m_axi_bready, 1'b1, "bready");
                b_cnt++;
                b_seen = 1'b1;
            end
            check_flag(aw_cnt - b_cnt <= MAX_OUT, 1'b1, "outstanding bursts within limit");
            if (rst_n && done_pulse) begin
                done_cnt++;
                check_flag(busy, 1'b0, "busy with done_pulse");
                check_flag(aw_cnt == exp_bursts, 1'b1, "AW count at done");
                check_flag(w_idx == exp_bursts * MB_BEATS, 1'b1, "beat count at done");
                check_flag(b_cnt == exp_bursts, 1'b1, "B count at done");
            end
        end
    end

    task automatic run_job();
        int n;
        aw_cnt = 0;
        w_idx = 0;
        w_bursts = 0;
        b_cnt = 0;
        done_cnt = 0;
        @(posedge clk);
        #10;
        mb_w = job_w;
        mb_h = job_h;
        base_addr = job_base;
        start_pulse = 1'b1;
        @(posedge clk);
        #10;
        start_pulse = 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b1, "busy after start");
        check_flag(resp_err, 1'b0, "resp_err after start");
        n = 0;
        while (done_cnt == 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("Timeout: done_pulse never arrived for the job");
        end
        // A second done would be an error
        repeat (3) @(negedge clk);
        check_flag(done_cnt == 1, 1'b1, "single done_pulse");
        check_flag(resp_err, err_en, "resp_err at job end");
    endtask

    // Next non-blank character after any comment lines
    task automatic next_tag(input int fd, output int c);
        c = $fgetc(fd);
        while (c == 32 || c == 9 || c == 10 || c == 13 || c == 35) begin
            if (c == 35) begin
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end
            c = $fgetc(fd);
        end
    endtask

    initial begin
        int fd, c, code, en;
        logic [DATA_W-1:0] word;
        start_pulse = 1'b0;
        mb_w = '0;
        mb_h = '0;
        base_addr = '0;
        enc_wr = 1'b0;
        enc_data = '0;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        m_axi_bvalid = 1'b0;
        m_axi_bresp = 2'b00;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_flag(m_axi_awvalid | m_axi_wvalid | m_axi_wlast | done_pulse | busy, 1'b0,
                   "any control output in reset");
        @(posedge clk);
        #10;
        rst_n = 1'b1;
        fd = $fopen("sim/mb_writeback_trace.txt", "r");
        if (fd == 0) abort_run("Could not open the trace file sim/mb_writeback_trace.txt");
        next_tag(fd, c);
        while (c == 74) begin
            code = $fscanf(fd, "%h %h %h %d %d %d", job_w, job_h, job_base, en, err_idx,
                           exp_bursts);
            if (code != 6) abort_run("Malformed job line in the trace file");
            err_en = (en != 0);
            check_flag(exp_bursts == (job_w % 2048) * (job_h % 2048), 1'b1,
                       "trace burst count");
            exp_words.delete();
            feed_idx = 0;
            for (int i = 0; i < exp_bursts; i++) begin
                next_tag(fd, c);
                if (c != 68) abort_run("Trace job has fewer payload lines than bursts");
                for (int b = 0; b < MB_BEATS; b++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) abort_run("Malformed payload line in the trace file");
                    exp_words.push_back(word);
                end
            end
            run_job();
            next_tag(fd, c);
        end
        $fclose(fd);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/mbw_pkg.sv
rtl/mb_job_if.sv
rtl/mb_fifo.sv
rtl/mb_wr_ctrl.sv
rtl/wdata_channel.sv
rtl/mb_writeback_top.sv
sim/tb_mb_writeback.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the macroblock write-back testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_mb_writeback -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// ==== sim/mb_writeback_trace.txt ====
# J mb_w mb_h base_addr err_en err_burst bursts (hex, hex, hex, dec, dec, dec)
# D seven payload words of one macroblock, in beat order (hex)
J 2 2 80000000 0 0 4
D 11000000 11000001 11000002 11000003 11000004 11000005 11000006
D 12a00010 12a00011 12a00012 12a00013 12a00014 12a00015 12a00016
D 13b00020 13b00021 13b00022 13b00023 13b00024 13b00025 13b00026
D 14c00030 14c00031 14c00032 14c00033 14c00034 14c00035 14c00036
J 800 5 80010000 0 0 0
J 3 1 80020000 1 1 3
D 3a5a0000 3a5a0001 3a5a0002 3a5a0003 3a5a0004 3a5a0005 3a5a0006
D 3b5b0100 3b5b0101 3b5b0102 3b5b0103 3b5b0104 3b5b0105 3b5b0106
D 3c5c0200 3c5c0201 3c5c0202 3c5c0203 3c5c0204 3c5c0205 3c5c0206
J 801 2 80030000 0 0 2
D 4f000000 4e000001 4d000002 4c000003 4b000004 4a000005 49000006
D 48000007 47000008 46000009 4500000a 4400000b 4300000c 4200000d
J 1 1 80040000 0 0 1
D 5dead000 5dead001 5dead002 5dead003 5dead004 5dead005 5dead006
